// ==== Makefile ====
TB_TOP  = tb_board_top
RTL_TOP = board_specific_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f filelist.f --top-module $(TB_TOP) --Mdir obj_dir -o sim_$(TB_TOP)

run: build
	./obj_dir/sim_$(TB_TOP) | tee sim.log
	@grep -qx "Result: PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(RTL_TOP)

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
hw/board_pkg.sv
hw/tm1638_pkg.sv
hw/lab_top.sv
hw/tm1638_frame_capture.sv
hw/tm1638_sio.sv
hw/tm1638_board_controller.sv
hw/board_specific_top.sv
test/tb_board_top.sv

// ==== hw/board_pkg.sv ====
package board_pkg;

    // board clock and front panel geometry
    localparam int clk_mhz = 27;
    localparam int n_digit = 8;
    localparam int n_key   = 8;
    localparam int n_led   = 8;

    // bit 0 is segment a, bit 7 is the point
    typedef logic [7:0] seg_t;

    typedef logic [n_key-1:0]   key_vec_t;
    typedef logic [n_led-1:0]   led_vec_t;
    typedef logic [n_digit-1:0] digit_sel_t;   // one-hot

    // value shown on the display, digit 0 holds the top nibble
    typedef logic [31:0] disp_val_t;

endpackage

// ==== hw/board_specific_top.sv ====
`timescale 1ns/1ps

module board_specific_top
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic [1:0] key,     // not connected on this board
    output logic [2:0] led,
    inout  wire  [4:0] gpio
);

    key_vec_t   tm_key;
    led_vec_t   tm_led;
    seg_t       abcdefgh;
    seg_t       hgfedcba;
    digit_sel_t digit;
    logic       sio_data_out;
    logic       sio_data_oe;

    lab_top i_lab_top (
        .clk      (clk),
        .arst_n   (arst_n),
        .key      (tm_key),
        .led      (tm_led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    always_comb
    begin
        for (int i = 0; i < $bits(seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg_t) - 1 - i];
    end

    tm1638_board_controller i_tm1638 (
        .clk          (clk),
        .arst_n       (arst_n),
        .hgfedcba     (hgfedcba),
        .digit        (digit),
        .ledr         (tm_led),
        .keys         (tm_key),
        .sio_clk      (gpio[2]),
        .sio_stb      (gpio[3]),
        .sio_data_out (sio_data_out),
        .sio_data_oe  (sio_data_oe),
        .sio_data_in  (gpio[4])
    );

    assign gpio[4] = sio_data_oe ? sio_data_out : 1'bz;   // DIO, chip drives it on key reads
    assign gpio[1] = 1'b0;   // module ground
    assign gpio[0] = 1'b1;   // module supply
    assign led     = tm_led[2:0];

endmodule

// ==== hw/lab_top.sv ====
`timescale 1ns/1ps

module lab_top
    import board_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  key_vec_t   key,
    output led_vec_t   led,
    output seg_t       abcdefgh,
    output digit_sel_t digit
);

    key_vec_t   key_r;
    key_vec_t   key_rise;
    logic [3:0] rise_idx;
    disp_val_t  value;
    logic [2:0] scan;        // digit being driven
    logic [3:0] nibble;

    function automatic seg_t hex_glyph(input logic [3:0] n);
        case (n)
            4'h0:    hex_glyph = 8'h3F;
            4'h1:    hex_glyph = 8'h06;
            4'h2:    hex_glyph = 8'h5B;
            4'h3:    hex_glyph = 8'h4F;
            4'h4:    hex_glyph = 8'h66;
            4'h5:    hex_glyph = 8'h6D;
            4'h6:    hex_glyph = 8'h7D;
            4'h7:    hex_glyph = 8'h07;
            4'h8:    hex_glyph = 8'h7F;
            4'h9:    hex_glyph = 8'h6F;
            4'hA:    hex_glyph = 8'h77;
            4'hB:    hex_glyph = 8'h7C;
            4'hC:    hex_glyph = 8'h39;
            4'hD:    hex_glyph = 8'h5E;
            4'hE:    hex_glyph = 8'h79;
            default: hex_glyph = 8'h71;
        endcase
    endfunction

    assign key_rise = key & ~key_r;

    // lowest pressed index wins
    always_comb
    begin
        rise_idx = '0;
        for (int k = n_key - 1; k >= 0; k--)
        begin
            if (key_rise[k])
                rise_idx = 4'(k);
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            key_r <= '0;
            value <= '0;
            scan  <= '0;
        end
        else
        begin
            key_r <= key;
            scan  <= scan + 1'b1;   // wraps after the last digit
            if (|key_rise)
                value <= {value[$bits(disp_val_t)-5:0], rise_idx};
        end
    end

    assign digit    = digit_sel_t'(1) << scan;
    assign nibble   = value[(n_digit - 1 - scan) * 4 +: 4];   // digit 0 is the top nibble
    assign abcdefgh = hex_glyph(nibble);
    assign led      = key;   // LEDs follow keys held

endmodule

// ==== hw/tm1638_board_controller.sv ====
`timescale 1ns/1ps

module tm1638_board_controller
    import board_pkg::*;
    import tm1638_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  seg_t       hgfedcba,
    input  digit_sel_t digit,
    input  led_vec_t   ledr,
    output key_vec_t   keys,
    output logic       sio_clk,
    output logic       sio_stb,
    output logic       sio_data_out,
    output logic       sio_data_oe,
    input  logic       sio_data_in
);

    tm_frame_t  frame;
    tm_frame_t  snap;         // frame being sent
    seq_state_t state;
    logic [3:0] idx;          // data address or read byte number
    logic       pending;      // byte in flight
    logic [$clog2(frame_cycles)-1:0] frame_cnt;
    logic       frame_tick;

    logic       byte_start;
    logic       byte_done;
    logic       rx_mode;
    logic       last;
    byte_t      tx_byte;
    byte_t      rx_byte;
    key_vec_t   key_acc;
    key_vec_t   key_next;

    tm1638_frame_capture i_capture (
        .clk      (clk),
        .arst_n   (arst_n),
        .hgfedcba (hgfedcba),
        .digit    (digit),
        .led      (ledr),
        .frame    (frame)
    );

    tm1638_sio i_sio (.*);

    assign frame_tick = (frame_cnt == $bits(frame_cnt)'(frame_cycles - 1));
    assign byte_start = (state != idle) && !pending;
    assign rx_mode    = (state == recv_keys);

    // byte for the current step
    always_comb
    begin
        tx_byte = '0;
        last    = 1'b0;
        case (state)
            send_mode: begin tx_byte = cmd_write_auto; last = 1'b1; end
            send_addr: tx_byte = cmd_addr0;
            send_data:
            begin
                // odd address carries the LED in bit 0
                tx_byte = idx[0] ? byte_t'(snap.led[idx[3:1]]) : snap.seg[idx[3:1]];
                last    = (idx == 4'(2 * n_digit - 1));
            end
            send_disp: begin tx_byte = cmd_display_on; last = 1'b1; end
            send_read: tx_byte = cmd_read_keys;
            recv_keys: last = (idx == 4'd3);
            default:   tx_byte = '0;
        endcase
    end

    // key k sits in bit 4*(k/4) of read byte k%4
    always_comb
    begin
        key_next = key_acc;
        key_next[{1'b0, idx[1:0]}] = rx_byte[0];
        key_next[{1'b1, idx[1:0]}] = rx_byte[4];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= idle;
            idx       <= '0;
            pending   <= 1'b0;
            frame_cnt <= '0;
            keys      <= '0;
        end
        else
        begin
            frame_cnt <= frame_tick ? '0 : frame_cnt + 1'b1;
            if (byte_start)
                pending <= 1'b1;
            else if (byte_done)
                pending <= 1'b0;

            if (state == idle && frame_tick)
                state <= send_mode;
            else if (byte_done)
            begin
                case (state)
                    send_mode: state <= send_addr;
                    send_addr: begin state <= send_data; idx <= '0; end
                    send_data:
                        if (last)
                            state <= send_disp;
                        else
                            idx <= idx + 1'b1;
                    send_disp: state <= send_read;
                    send_read: begin state <= recv_keys; idx <= '0; end
                    recv_keys:
                        if (last)
                        begin
                            keys  <= key_next;   // all four bytes in
                            state <= idle;
                        end
                        else
                            idx <= idx + 1'b1;
                    default:   state <= idle;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == idle && frame_tick)
            snap <= frame;
        if (byte_done && state == recv_keys)
            key_acc <= key_next;
    end

endmodule

// ==== hw/tm1638_frame_capture.sv ====
`timescale 1ns/1ps

module tm1638_frame_capture
    import board_pkg::*;
    import tm1638_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  seg_t       hgfedcba,
    input  digit_sel_t digit,
    input  led_vec_t   led,
    output tm_frame_t  frame
);

    logic [$clog2(n_digit)-1:0] slot;
    seg_t                       seg_a_first;

    // one-hot strobe to slot number
    always_comb
    begin
        slot = '0;
        for (int i = 0; i < n_digit; i++)
        begin
            if (digit[i])
                slot = $bits(slot)'(i);
        end
    end

    // back to a-first order for the chip
    always_comb
    begin
        for (int i = 0; i < $bits(seg_t); i++)
            seg_a_first[i] = hgfedcba[$bits(seg_t) - 1 - i];
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            frame <= '0;
        end
        else
        begin
            frame.seg[slot] <= seg_a_first;
            frame.led       <= led;
        end
    end

endmodule

// ==== hw/tm1638_pkg.sv ====
package tm1638_pkg;

    // command bytes
    localparam logic [7:0] cmd_write_auto = 8'h40;   // data write, address auto increment
    localparam logic [7:0] cmd_read_keys  = 8'h42;
    localparam logic [7:0] cmd_addr0      = 8'hC0;
    localparam logic [7:0] cmd_display_on = 8'h8F;   // display on, full brightness

    // system clocks per half period of sio_clk
    localparam int sio_div = 2;

    // system clocks from one frame start to the next
    localparam int frame_cycles = 1024;

    typedef logic [7:0] byte_t;

    // what one refresh sends to the chip
    typedef struct packed {
        board_pkg::seg_t [board_pkg::n_digit-1:0] seg;   // seg[i] goes to digit i
        board_pkg::led_vec_t                      led;
    } tm_frame_t;

    // refresh sequencer, one state per command of the frame
    typedef enum logic [2:0] {
        idle,
        send_mode,
        send_addr,
        send_data,
        send_disp,
        send_read,
        recv_keys
    } seq_state_t;

endpackage

// ==== hw/tm1638_sio.sv ====
`timescale 1ns/1ps

module tm1638_sio
    import tm1638_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  byte_start,
    input  logic  rx_mode,
    input  logic  last,
    input  byte_t tx_byte,
    output logic  byte_done,
    output byte_t rx_byte,
    output logic  sio_clk,
    output logic  sio_stb,
    output logic  sio_data_out,
    output logic  sio_data_oe,
    input  logic  sio_data_in
);

    typedef enum logic [2:0] {
        s_idle,
        s_lead,     // strobe low, first clock not yet
        s_low,
        s_high,
        s_tail,     // last bit done, strobe goes up
        s_gap       // strobe high before the next command
    } sio_state_t;

    sio_state_t              state;
    logic [$clog2(sio_div):0] div_cnt;
    logic                    half_tick;
    logic [2:0]              bit_cnt;
    byte_t                   tx_sr;
    logic                    rx_r;
    logic                    last_r;

    assign half_tick = (div_cnt == $bits(div_cnt)'(sio_div - 1));

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= s_idle;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            rx_r         <= 1'b0;
            last_r       <= 1'b0;
            byte_done    <= 1'b0;
            sio_clk      <= 1'b1;
            sio_stb      <= 1'b1;
            sio_data_out <= 1'b1;
            sio_data_oe  <= 1'b1;
        end
        else
        begin
            byte_done <= 1'b0;
            if (state == s_idle || half_tick)
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;

            case (state)
                s_idle:
                    if (byte_start)
                    begin
                        rx_r    <= rx_mode;
                        last_r  <= last;
                        bit_cnt <= '0;
                        if (sio_stb)
                        begin
                            sio_stb <= 1'b0;   // new command
                            state   <= s_lead;
                        end
                        else
                        begin
                            sio_clk      <= 1'b0;
                            sio_data_out <= rx_mode | tx_byte[0];
                            sio_data_oe  <= !rx_mode;
                            state        <= s_low;
                        end
                    end
                s_lead:
                    if (half_tick)
                    begin
                        sio_clk      <= 1'b0;
                        sio_data_out <= rx_r | tx_sr[0];
                        sio_data_oe  <= !rx_r;
                        state        <= s_low;
                    end
                s_low:
                    if (half_tick)
                    begin
                        sio_clk <= 1'b1;   // chip samples here
                        state   <= s_high;
                    end
                s_high:
                    if (half_tick)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            if (last_r)
                            begin
                                state <= s_tail;
                            end
                            else
                            begin
                                byte_done <= 1'b1;
                                state     <= s_idle;
                            end
                        end
                        else
                        begin
                            bit_cnt      <= bit_cnt + 1'b1;
                            sio_clk      <= 1'b0;
                            sio_data_out <= rx_r | tx_sr[1];
                            state        <= s_low;
                        end
                    end
                s_tail:
                    if (half_tick)
                    begin
                        sio_stb      <= 1'b1;
                        sio_data_out <= 1'b1;
                        sio_data_oe  <= 1'b1;   // take the line back after a read
                        state        <= s_gap;
                    end
                s_gap:
                    if (half_tick)
                    begin
                        byte_done <= 1'b1;
                        state     <= s_idle;
                    end
                default:
                    state <= s_idle;
            endcase
        end
    end

    // shift registers, LSB first both ways
    always_ff @(posedge clk)
    begin
        if (state == s_idle && byte_start)
            tx_sr <= tx_byte;
        else if (state == s_high && half_tick)
            tx_sr <= tx_sr >> 1;

        if (state == s_low && half_tick && rx_r)
            rx_byte <= {sio_data_in, rx_byte[7:1]};
    end

endmodule

// ==== test/tb_board_top.sv ====
`timescale 1ns/1ps

module tb_board_top
    import board_pkg::*;
    import tm1638_pkg::*;
();

    logic       clk = 1'b0;
    logic       arst_n;
    logic [1:0] board_key;
    logic [2:0] board_led;
    wire  [4:0] gpio;

    // TM1638 model state
    logic       chip_oe = 1'b0;
    logic       chip_do = 1'b1;
    byte_t      key_bytes [4];
    byte_t      win_bytes [17];    // bytes of the current strobe window
    byte_t      shift = '0;
    int         n_bits = 0;
    int         n_bytes = 0;
    logic       reading = 1'b0;
    int         rd_bit = 0;
    int         win = 0;           // command number inside the frame
    byte_t      disp_mem [16];
    byte_t      last_disp [16];    // display bytes of the last complete frame
    int         frames_seen = 0;

    byte_t      exp_cmd [4] = '{8'h40, 8'hC0, 8'h8F, 8'h42};
    int         exp_len [4] = '{1, 17, 1, 1};
    seg_t       glyph [16] = '{8'h3F, 8'h06, 8'h5B, 8'h4F, 8'h66, 8'h6D, 8'h7D, 8'h07,
                               8'h7F, 8'h6F, 8'h77, 8'h7C, 8'h39, 8'h5E, 8'h79, 8'h71};

    logic [31:0] kb_q [$];         // key bytes with byte 0 in the low bits
    disp_val_t   val_q [$];
    led_vec_t    led_q [$];
    int          n_steps = 0;

    int seg_errors = 0;
    int led_errors = 0;
    int byte_errors = 0;
    int other_errors = 0;

    board_specific_top i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .key    (board_key),
        .led    (board_led),
        .gpio   (gpio)
    );

    always #4 clk = ~clk;

    pullup (gpio[4]);
    assign gpio[4] = chip_oe ? chip_do : 1'bz;   // chip answers key reads on DIO

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp)
        begin
            seg_errors++;
            $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_led(input string name, input led_vec_t got, input led_vec_t exp);
        if (got !== exp)
        begin
            led_errors++;
            $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            byte_errors++;
            $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // key k is bit 4*(k/4) of read byte k%4
    function automatic led_vec_t keys_from_bytes(input logic [31:0] kb);
        led_vec_t v;
        for (int k = 0; k < n_key; k++)
            v[k] = kb[(k % 4) * 8 + 4 * (k / 4)];
        return v;
    endfunction

    task automatic compare_frame(input string tag, input disp_val_t val, input led_vec_t leds);
        for (int i = 0; i < n_digit; i++)
        begin
            check_seg($sformatf("%s seg%0d", tag, i), last_disp[2 * i],
                      glyph[val[(n_digit - 1 - i) * 4 +: 4]]);   // digit 0 is the top nibble
            check_byte($sformatf("%s led%0d", tag, i), last_disp[2 * i + 1],
                       {7'b0, leds[i]});
        end
    endtask

    always @(negedge gpio[3])
    begin
        n_bits  = 0;
        n_bytes = 0;
        reading = 1'b0;
        rd_bit  = 0;
    end

    // chip samples DIO LSB first on the rising clock
    always @(posedge gpio[2])
    begin
        if (gpio[3] === 1'b0 && !reading)
        begin
            shift = {gpio[4], shift[7:1]};
            n_bits++;
            if (n_bits == 8)
            begin
                n_bits = 0;
                if (n_bytes < 17)
                    win_bytes[n_bytes] = shift;
                n_bytes++;
                if (n_bytes == 1 && shift == 8'h42)
                    reading = 1'b1;
            end
        end
    end

    always @(negedge gpio[2])
    begin
        if (gpio[3] === 1'b0 && reading && rd_bit < 32)
        begin
            chip_oe = 1'b1;
            chip_do = key_bytes[rd_bit / 8][rd_bit % 8];
            rd_bit++;
        end
    end

    // end of a command window
    always @(posedge gpio[3])
    begin
        chip_oe = 1'b0;
        if (n_bytes > 0)
        begin
            check_byte($sformatf("command %0d", win), win_bytes[0], exp_cmd[win]);
            if (n_bytes != exp_len[win] || n_bits != 0)
            begin
                other_errors++;
                $display("window %0d carried %0d bytes and %0d stray bits, expected %0d bytes",
                         win, n_bytes, n_bits, exp_len[win]);
            end
            if (win == 1)
            begin
                for (int i = 0; i < 16; i++)
                    disp_mem[i] = win_bytes[i + 1];
            end
            if (win == 3)
            begin
                if (rd_bit != 32)
                begin
                    other_errors++;
                    $display("key read clocked %0d bits instead of 32", rd_bit);
                end
                last_disp = disp_mem;
                frames_seen++;
            end
            win = (win + 1) % 4;
        end
    end

    initial
    begin
        wait (n_steps > 0);
        #(longint'(n_steps + 2) * 3 * frame_cycles * 8);
        $display("timeout: frames stopped arriving, %0d frames seen", frames_seen);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        int          fd;
        int          target;
        string       line;
        byte_t       b0, b1, b2, b3;
        disp_val_t   v;
        led_vec_t    l;
        disp_val_t   prev_val;
        led_vec_t    prev_led;

        arst_n    = 1'b0;
        board_key = 2'b00;
        for (int i = 0; i < 4; i++)
            key_bytes[i] = '0;

        fd = $fopen("test/tm1638_trace.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("could not open test/tm1638_trace.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#")
                begin
                    if ($sscanf(line, "%h %h %h %h %h %h", b0, b1, b2, b3, v, l) == 6)
                    begin
                        kb_q.push_back({b3, b2, b1, b0});
                        val_q.push_back(v);
                        led_q.push_back(l);
                    end
                end
            end
            $fclose(fd);
            n_steps = kb_q.size();
            if (n_steps == 0)
            begin
                other_errors++;
                $display("test/tm1638_trace.txt holds no trace steps");
            end
        end

        repeat (2) @(negedge clk);
        check_byte("gpio in reset", {3'b000, gpio}, 8'h1D);
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_byte("gpio after reset", {3'b000, gpio}, 8'h1D);

        prev_val = '0;   // first frame shows the reset state
        prev_led = '0;
        for (int s = 0; s < n_steps; s++)
        begin
            {key_bytes[3], key_bytes[2], key_bytes[1], key_bytes[0]} = kb_q[s];
            check_led($sformatf("trace line %0d led", s), led_q[s], keys_from_bytes(kb_q[s]));

            target = frames_seen + 1;   // this frame reads the new bytes
            wait (frames_seen == target);
            @(negedge clk);
            compare_frame($sformatf("step %0d frame A", s), prev_val, prev_led);

            target = frames_seen + 1;
            wait (frames_seen == target);
            @(negedge clk);
            compare_frame($sformatf("step %0d frame B", s), val_q[s], led_q[s]);
            check_led($sformatf("step %0d board led", s), {5'b0, board_led},
                      {5'b0, led_q[s][2:0]});

            prev_val = val_q[s];
            prev_led = led_q[s];
        end

        $display("errors: seg %0d, led %0d, byte %0d, other %0d",
                 seg_errors, led_errors, byte_errors, other_errors);
        if (seg_errors + led_errors + byte_errors + other_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== test/tm1638_trace.txt ====
# key byte 0, key byte 1, key byte 2, key byte 3 as read from the chip (hex)
# expected display value (hex, digit 0 is the top nibble), expected LED byte (hex)
00 00 00 00 00000000 00
00 00 00 01 00000003 08
00 00 00 00 00000003 00
00 00 00 01 00000033 08
00 10 00 01 00000335 28
00 10 00 01 00000335 28
02 20 04 40 00000335 00
00 00 00 10 00003357 80
00 00 00 00 00003357 00
00 00 11 00 00033572 44
00 00 00 00 00033572 00
10 00 00 00 00335724 10
00 00 00 00 00335724 00
00 01 00 00 03357241 02
00 00 00 00 03357241 00
01 00 00 00 33572410 01
01 00 10 00 35724106 41
00 00 00 00 35724106 00
00 10 00 00 57241065 20
00 00 00 00 57241065 00
00 11 00 01 72410651 2A
EE EE EE EE 72410651 00
00 00 01 00 24106512 04
